// ==== Bender.yml ====
package:
  name: controlUnit

sources:
  - design/cpuCtrlPkg.sv
  - design/stateSequencer.sv
  - design/controlDecoder.sv
  - design/controlUnit.sv
  - target: simulation
    files:
      - bench/controlUnitSva.sv
      - bench/controlUnitTb.sv

// ==== bench/controlUnitSva.sv ====
`timescale 1ns/1ps

module controlUnitSva
	import cpuCtrlPkg::*;
(
	input logic clk,
	input logic rst,
	input ctrlWord ctrl
);

	int failCount = 0;

	// Stores always go through STP
	writeUsesStp: assert property (@(posedge clk) disable iff (rst)
		ctrl.mem == memWrite |-> ctrl.ptr == pStp)
	else begin
		$error("memory write without the STP pointer");
		failCount++;
	end

	addUsesAddr: assert property (@(posedge clk) disable iff (rst)
		ctrl.alu == aluAdd |-> ctrl.bus == bsAddr)
	else begin
		$error("add without ADDR on the bus");
		failCount++;
	end

	noWriteResetOverlap: assert property (@(posedge clk) disable iff (rst)
		(ctrl.wrtEn & ctrl.rstEn) == '0)
	else begin
		$error("a register is written and reset in the same cycle");
		failCount++;
	end

	idleAfterReset: assert property (@(posedge clk) rst |=> ctrl == idleWord)
	else begin
		$error("control word not idle after a reset cycle");
		failCount++;
	end

endmodule

bind controlUnit controlUnitSva sva0 (.clk(clk), .rst(rst), .ctrl(ctrl));

// ==== bench/controlUnitTb.sv ====
`timescale 1ns/1ps

module controlUnitTb
	import cpuCtrlPkg::*;
();

	localparam int halfPeriod = 50;
	localparam int resetCycles = 3;
	// Reset test, groups, jumps, random stream, halt
	localparam int instrCount = 1 + 13 + 6 + 13 + 5 + 40 + 1;
	localparam int maxInstrCycles = 7;
	localparam int watchdogCycles = 2 * resetCycles + 12 + instrCount * maxInstrCycles + 100;

	logic clk;
	logic rst;
	insOpcode ins;
	logic z1;
	logic z2;
	ctrlWord ctrl;

	logic [31:0] lfsrState = 32'h8ee8fff8;

	// Same order as the instruction groups
	insOpcode legalOps [35] = '{
		opRstAll, opRstAc, opRstAddr, opRstGsp, opRstMc, opRstCp, opRstRp,
		opIncGsp, opIncAc, opIncCp, opIncRp, opIncMc, opIncStp,
		opLdAddr, opLdAc, opLdMulr, opLdRp, opLdCp, opStSp,
		opAdd, opMstp, opMrp, opMcp, opMwv, opMeopc, opMaddr, opMcid, opMmv,
		opMcidAc, opMrpAc, opMcpAc, opMstpAc,
		opJmpZ1, opJmpZ2, opJmp
	};

	controlUnit dut0 (
		.clk  (clk),
		.rst  (rst),
		.ins  (ins),
		.z1   (z1),
		.z2   (z2),
		.ctrl (ctrl)
	);

	always #halfPeriod clk = ~clk;

	function automatic logic lfsrStep();
		logic fb;
		fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		lfsrState = {lfsrState[30:0], fb};
		return fb;
	endfunction

	function automatic int drawBits(input int count);
		int v;
		v = 0;
		for (int i = 0; i < count; i++)
			v = (v << 1) | int'(lfsrStep());
		return v;
	endfunction

	function automatic regMask oneHot(input regIndex r);
		regMask m;
		m = '0;
		m[r] = 1'b1;
		return m;
	endfunction

	function automatic ctrlWord fetchWord();
		ctrlWord w;
		w = idleWord;
		w.incEn = oneHot(riPc);
		w.wrtEn = oneHot(riIr);
		return w;
	endfunction

	// Expected words from stFetch2 up to the next stFetch1
	function automatic int expectSeq(input insOpcode op, input logic f1, input logic f2,
			output ctrlWord seq [8]);
		ctrlWord w;
		ctrlWord step;
		int n;
		logic taken;
		for (int i = 0; i < 8; i++)
			seq[i] = idleWord;
		seq[0] = fetchWord();
		n = 1;
		w = idleWord;
		case (op)
			opRstAll:  w.rstEn = ~(oneHot(riPc) | oneHot(riIr));
			opRstAc:   w.rstEn = oneHot(riAc);
			opRstAddr: w.rstEn = oneHot(riAddr);
			opRstGsp:  w.rstEn = oneHot(riGsp);
			opRstMc:   w.rstEn = oneHot(riMc);
			opRstCp:   w.rstEn = oneHot(riCp);
			opRstRp:   w.rstEn = oneHot(riRp);
			opIncGsp:  w.incEn = oneHot(riGsp);
			opIncAc:   w.incEn = oneHot(riAc);
			opIncCp:   w.incEn = oneHot(riCp);
			opIncRp:   w.incEn = oneHot(riRp);
			opIncMc:   w.incEn = oneHot(riMc);
			opIncStp:  w.incEn = oneHot(riStp);
			opLdAddr:  w.wrtEn = oneHot(riAddr);
			opLdAc, opLdCp:   w.wrtEn = oneHot(riAc);
			opLdMulr, opLdRp: w.wrtEn = oneHot(riMulr);
			opStSp: begin
				w.mem = memWrite;
				w.ptr = pStp;
			end
			opAdd: begin
				w.alu = aluAdd;
				w.bus = bsAddr;
			end
			opMstp:  w.wrtEn = oneHot(riStp);
			opMrp:   w.wrtEn = oneHot(riRp);
			opMcp:   w.wrtEn = oneHot(riCp);
			opMwv:   w.wrtEn = oneHot(riWv);
			opMeopc: w.wrtEn = oneHot(riEopc);
			opMaddr: w.wrtEn = oneHot(riAddr);
			opMcid:  w.wrtEn = oneHot(riCid);
			opMmv:   w.wrtEn = oneHot(riMv);
			opMcidAc, opMrpAc, opMcpAc, opMstpAc: begin
				w.wrtEn = oneHot(riAc);
				w.bus = (op == opMcidAc) ? bsCid : (op == opMrpAc) ? bsRp :
					(op == opMcpAc) ? bsCp : bsStp;
			end
			default: w = idleWord;
		endcase
		step = idleWord;
		if (op inside {opLdAddr, opLdAc, opLdMulr, opLdRp, opLdCp}) begin
			step.mem = memRead;
			step.ptr = (op == opLdRp) ? pRp : (op == opLdCp) ? pCp : pGsp;
			seq[n++] = step;
			w.bus = bsMemOut;
			seq[n++] = w;
		end else if (op inside {opJmpZ1, opJmpZ2}) begin
			taken = (op == opJmpZ1) ? f1 : !f2;
			seq[n++] = idleWord;
			if (taken) begin
				step.wrtEn = oneHot(riIr);
				seq[n++] = step;
				step.wrtEn = oneHot(riPc);
				seq[n++] = step;
			end else begin
				step.incEn = oneHot(riPc);
				step.wrtEn = oneHot(riIr);
				seq[n++] = step;
			end
			seq[n++] = idleWord;
		end else if (op == opJmp) begin
			seq[n++] = idleWord;
			seq[n++] = idleWord;
			step.wrtEn = oneHot(riPc);
			seq[n++] = step;
			seq[n++] = idleWord;
		end else begin
			seq[n++] = w;
		end
		// Back in stFetch1
		seq[n++] = idleWord;
		return n;
	endfunction

	task automatic checkWord(input ctrlWord exp, input string what);
		assert (ctrl === exp) else begin
			$display("MISMATCH at %0t ns: %s, expected %h, got %h", $time, what, exp, ctrl);
			$display("Something failed");
			$fatal(1, "Control word check failed");
		end
	endtask

	task automatic nextCycle();
		@(posedge clk);
		@(negedge clk);
	endtask

	// Starts and ends on a falling edge in a stFetch1 cycle
	task automatic runInstr(input insOpcode op, input logic f1, input logic f2);
		ctrlWord seq [8];
		int len;
		len = expectSeq(op, f1, f2, seq);
		ins = op;
		z1 = f1;
		z2 = f2;
		for (int i = 0; i < len; i++) begin
			nextCycle();
			checkWord(seq[i], $sformatf("%s step %0d", op.name(), i));
		end
	endtask

	task automatic applyReset();
		rst = 1'b1;
		repeat (resetCycles) begin
			nextCycle();
			checkWord(idleWord, "idle word under reset");
		end
		rst = 1'b0;
	endtask

	task automatic testReset();
		applyReset();
		runInstr(opIncAc, 1'b0, 1'b0);
	endtask

	task automatic runRange(input int first, input int last);
		for (int i = first; i <= last; i++)
			runInstr(legalOps[i], 1'b0, 1'b0);
	endtask

	task automatic testJumps();
		runInstr(opJmpZ1, 1'b0, 1'b1);
		runInstr(opJmpZ1, 1'b1, 1'b0);
		runInstr(opJmpZ2, 1'b1, 1'b0);
		runInstr(opJmpZ2, 1'b0, 1'b1);
		runInstr(opJmp, 1'b1, 1'b1);
	endtask

	task automatic testMixedHalt();
		insOpcode op;
		logic f1;
		logic f2;
		repeat (40) begin
			op = legalOps[drawBits(6) % 35];
			f1 = lfsrStep();
			f2 = lfsrStep();
			runInstr(op, f1, f2);
		end
		ins = insOpcode'(8'hff);
		nextCycle();
		checkWord(fetchWord(), "fetch of an illegal byte");
		repeat (10) begin
			nextCycle();
			checkWord(idleWord, "halt state holds idle");
		end
		applyReset();
		runInstr(opRstAll, 1'b0, 1'b0);
	endtask

	initial begin
		#(watchdogCycles * 2 * halfPeriod);
		$display("Timeout: the tests did not finish within %0d cycles", watchdogCycles);
		$display("Something failed");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		wait (dut0.sva0.failCount != 0);
		$display("A bound assertion on the control word failed at %0t ns", $time);
		$display("Something failed");
		$fatal(1, "Bound assertion failed");
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		ins = opRstAll;
		z1 = 1'b0;
		z2 = 1'b0;
		testReset();
		runRange(0, 12);
		runRange(13, 18);
		runRange(19, 31);
		testJumps();
		testMixedHalt();
		if (dut0.sva0.failCount == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			$display("Something failed");
			$fatal(1, "Bound assertions reported errors");
		end
	end

endmodule

// ==== controlUnit.f ====
design/cpuCtrlPkg.sv
design/stateSequencer.sv
design/controlDecoder.sv
design/controlUnit.sv
bench/controlUnitSva.sv
bench/controlUnitTb.sv

// ==== design/controlDecoder.sv ====
`timescale 1ns/1ps

module controlDecoder
	import cpuCtrlPkg::*;
(
	input logic clk,
	input logic rst,
	input microState nextState,
	output ctrlWord ctrl
);

	ctrlWord word;

	// Word of the state about to be entered
	always_comb begin
		word = idleWord;
		case (nextState)
			stFetch2: begin
				word.incEn = maskOf(riPc);
				word.wrtEn = maskOf(riIr);
			end

			// Everything but PC and IR
			stRstAll:  word.rstEn = ~(maskOf(riPc) | maskOf(riIr));
			stRstAc:   word.rstEn = maskOf(riAc);
			stRstAddr: word.rstEn = maskOf(riAddr);
			stRstGsp:  word.rstEn = maskOf(riGsp);
			stRstMc:   word.rstEn = maskOf(riMc);
			stRstCp:   word.rstEn = maskOf(riCp);
			stRstRp:   word.rstEn = maskOf(riRp);

			stIncGsp: word.incEn = maskOf(riGsp);
			stIncAc:  word.incEn = maskOf(riAc);
			stIncCp:  word.incEn = maskOf(riCp);
			stIncRp:  word.incEn = maskOf(riRp);
			stIncMc:  word.incEn = maskOf(riMc);
			stIncStp: word.incEn = maskOf(riStp);

			// Memory read through the selected pointer
			stLdAddr1, stLdAc1, stLdMulr1: word.mem = memRead;
			stLdRp1: begin
				word.mem = memRead;
				word.ptr = pRp;
			end
			stLdCp1: begin
				word.mem = memRead;
				word.ptr = pCp;
			end

			// Memory data onto the bus
			stLdAddr2: begin
				word.bus = bsMemOut;
				word.wrtEn = maskOf(riAddr);
			end
			stLdAc2, stLdCp2: begin
				word.bus = bsMemOut;
				word.wrtEn = maskOf(riAc);
			end
			stLdMulr2, stLdRp2: begin
				word.bus = bsMemOut;
				word.wrtEn = maskOf(riMulr);
			end

			stStSp: begin
				word.mem = memWrite;
				word.ptr = pStp;
			end

			stAdd: begin
				word.alu = aluAdd;
				word.bus = bsAddr;
			end

			// AC to register moves
			stMstp:  word.wrtEn = maskOf(riStp);
			stMrp:   word.wrtEn = maskOf(riRp);
			stMcp:   word.wrtEn = maskOf(riCp);
			stMwv:   word.wrtEn = maskOf(riWv);
			stMeopc: word.wrtEn = maskOf(riEopc);
			stMaddr: word.wrtEn = maskOf(riAddr);
			stMcid:  word.wrtEn = maskOf(riCid);
			stMmv:   word.wrtEn = maskOf(riMv);

			stMcidAc: begin
				word.bus = bsCid;
				word.wrtEn = maskOf(riAc);
			end
			stMrpAc: begin
				word.bus = bsRp;
				word.wrtEn = maskOf(riAc);
			end
			stMcpAc: begin
				word.bus = bsCp;
				word.wrtEn = maskOf(riAc);
			end
			stMstpAc: begin
				word.bus = bsStp;
				word.wrtEn = maskOf(riAc);
			end

			// Jump target into IR, then into PC
			stJmpZ1Y1, stJmpZ2Y1:         word.wrtEn = maskOf(riIr);
			stJmpZ1Y2, stJmpZ2Y2, stJmp3: word.wrtEn = maskOf(riPc);

			// Not taken skips the operand byte
			stJmpZ1N1, stJmpZ2N1: begin
				word.incEn = maskOf(riPc);
				word.wrtEn = maskOf(riIr);
			end

			// Fetch1, flag tests, tail steps and halt stay idle
			default: word = idleWord;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			ctrl <= idleWord;
		else
			ctrl <= word;
	end

endmodule

// ==== design/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit
	import cpuCtrlPkg::*;
(
	input logic clk,
	input logic rst,
	input insOpcode ins,
	input logic z1,
	input logic z2,
	output ctrlWord ctrl
);

	microState nextState;

	stateSequencer sequencer0 (
		.clk       (clk),
		.rst       (rst),
		.ins       (ins),
		.z1        (z1),
		.z2        (z2),
		.nextState (nextState)
	);

	// Registers the word of the state being entered
	controlDecoder decoder0 (
		.clk       (clk),
		.rst       (rst),
		.nextState (nextState),
		.ctrl      (ctrl)
	);

endmodule

// ==== design/cpuCtrlPkg.sv ====
package cpuCtrlPkg;

	localparam int regCount = 14;

	// Instruction bytes, grouped by high nibble
	typedef enum logic [7:0] {
		opRstAll  = 8'h10,
		opRstAc   = 8'h11,
		opRstAddr = 8'h12,
		opRstGsp  = 8'h13,
		opRstMc   = 8'h14,
		opRstCp   = 8'h15,
		opRstRp   = 8'h16,
		opIncGsp  = 8'h20,
		opIncAc   = 8'h21,
		opIncCp   = 8'h22,
		opIncRp   = 8'h23,
		opIncMc   = 8'h24,
		opIncStp  = 8'h25,
		opLdAddr  = 8'h30,
		opLdAc    = 8'h31,
		opLdMulr  = 8'h32,
		opLdRp    = 8'h33,
		opLdCp    = 8'h34,
		opStSp    = 8'h40,
		opAdd     = 8'h41,
		opMstp    = 8'h50,
		opMrp     = 8'h51,
		opMcp     = 8'h52,
		opMwv     = 8'h53,
		opMeopc   = 8'h54,
		opMaddr   = 8'h55,
		opMcid    = 8'h56,
		opMmv     = 8'h57,
		opMcidAc  = 8'h60,
		opMrpAc   = 8'h61,
		opMcpAc   = 8'h62,
		opMstpAc  = 8'h63,
		opJmpZ1   = 8'h70,
		opJmpZ2   = 8'h71,
		opJmp     = 8'h72
	} insOpcode;

	typedef enum logic [7:0] {
		stFetch1 = 8'h00,
		stFetch2,
		stEndOp,
		stRstAll, stRstAc, stRstAddr, stRstGsp, stRstMc, stRstCp, stRstRp,
		stIncGsp, stIncAc, stIncCp, stIncRp, stIncMc, stIncStp,
		stLdAddr1, stLdAddr2,
		stLdAc1, stLdAc2,
		stLdMulr1, stLdMulr2,
		stLdRp1, stLdRp2,
		stLdCp1, stLdCp2,
		stStSp,
		stAdd,
		stMstp, stMrp, stMcp, stMwv, stMeopc, stMaddr, stMcid, stMmv,
		stMcidAc, stMrpAc, stMcpAc, stMstpAc,
		stJmpZ1, stJmpZ1Y1, stJmpZ1Y2, stJmpZ1Y3, stJmpZ1N1, stJmpZ1N2,
		stJmpZ2, stJmpZ2Y1, stJmpZ2Y2, stJmpZ2Y3, stJmpZ2N1, stJmpZ2N2,
		stJmp1, stJmp2, stJmp3, stJmp4
	} microState;

	// Bit positions in the register masks, LSB first
	typedef enum logic [3:0] {
		riPc   = 4'd0,
		riIr   = 4'd1,
		riGsp  = 4'd2,
		riRp   = 4'd3,
		riCp   = 4'd4,
		riStp  = 4'd5,
		riCid  = 4'd6,
		riEopc = 4'd7,
		riMc   = 4'd8,
		riMv   = 4'd9,
		riWv   = 4'd10,
		riMulr = 4'd11,
		riAddr = 4'd12,
		riAc   = 4'd13
	} regIndex;

	typedef logic [regCount-1:0] regMask;

	typedef enum logic [2:0] {
		aluNone = 3'd0,
		aluAdd  = 3'd1
	} aluOp;

	typedef enum logic [3:0] {
		bsMemOut = 4'd0,
		bsAc     = 4'd1,
		bsAddr   = 4'd2,
		bsCid    = 4'd3,
		bsRp     = 4'd4,
		bsCp     = 4'd5,
		bsStp    = 4'd6
	} busSel;

	typedef enum logic [1:0] {
		pGsp = 2'd0,
		pRp  = 2'd1,
		pCp  = 2'd2,
		pStp = 2'd3
	} ptrSel;

	typedef enum logic [3:0] {
		memIdle  = 4'd0,
		memRead  = 4'd1,
		memWrite = 4'd2
	} memCmd;

	// 55 bits in all
	typedef struct packed {
		aluOp   alu;
		busSel  bus;
		ptrSel  ptr;
		memCmd  mem;
		regMask wrtEn;
		regMask incEn;
		regMask rstEn;
	} ctrlWord;

	localparam ctrlWord idleWord = '{
		alu:   aluNone,
		bus:   bsAc,
		ptr:   pGsp,
		mem:   memIdle,
		wrtEn: '0,
		incEn: '0,
		rstEn: '0
	};

	function automatic regMask maskOf(input regIndex r);
		return regMask'(1) << r;
	endfunction

endpackage

// ==== design/stateSequencer.sv ====
`timescale 1ns/1ps

module stateSequencer
	import cpuCtrlPkg::*;
(
	input logic clk,
	input logic rst,
	input insOpcode ins,
	input logic z1,
	input logic z2,
	output microState nextState
);

	microState state;

	// First execute state of each instruction
	function automatic microState entryOf(input insOpcode op);
		case (op)
			opRstAll:  return stRstAll;
			opRstAc:   return stRstAc;
			opRstAddr: return stRstAddr;
			opRstGsp:  return stRstGsp;
			opRstMc:   return stRstMc;
			opRstCp:   return stRstCp;
			opRstRp:   return stRstRp;
			opIncGsp:  return stIncGsp;
			opIncAc:   return stIncAc;
			opIncCp:   return stIncCp;
			opIncRp:   return stIncRp;
			opIncMc:   return stIncMc;
			opIncStp:  return stIncStp;
			opLdAddr:  return stLdAddr1;
			opLdAc:    return stLdAc1;
			opLdMulr:  return stLdMulr1;
			opLdRp:    return stLdRp1;
			opLdCp:    return stLdCp1;
			opStSp:    return stStSp;
			opAdd:     return stAdd;
			opMstp:    return stMstp;
			opMrp:     return stMrp;
			opMcp:     return stMcp;
			opMwv:     return stMwv;
			opMeopc:   return stMeopc;
			opMaddr:   return stMaddr;
			opMcid:    return stMcid;
			opMmv:     return stMmv;
			opMcidAc:  return stMcidAc;
			opMrpAc:   return stMrpAc;
			opMcpAc:   return stMcpAc;
			opMstpAc:  return stMstpAc;
			opJmpZ1:   return stJmpZ1;
			opJmpZ2:   return stJmpZ2;
			opJmp:     return stJmp1;
			// Unknown byte halts the machine
			default:   return stEndOp;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (rst)
			state <= stFetch1;
		else
			state <= nextState;
	end

	always_comb begin
		case (state)
			stFetch1: nextState = stFetch2;
			stFetch2: nextState = entryOf(ins);

			// Two-step loads
			stLdAddr1: nextState = stLdAddr2;
			stLdAc1:   nextState = stLdAc2;
			stLdMulr1: nextState = stLdMulr2;
			stLdRp1:   nextState = stLdRp2;
			stLdCp1:   nextState = stLdCp2;

			// Z1 set means taken
			stJmpZ1:   nextState = z1 ? stJmpZ1Y1 : stJmpZ1N1;
			stJmpZ1Y1: nextState = stJmpZ1Y2;
			stJmpZ1Y2: nextState = stJmpZ1Y3;
			stJmpZ1N1: nextState = stJmpZ1N2;

			// Z2 clear means taken
			stJmpZ2:   nextState = z2 ? stJmpZ2N1 : stJmpZ2Y1;
			stJmpZ2Y1: nextState = stJmpZ2Y2;
			stJmpZ2Y2: nextState = stJmpZ2Y3;
			stJmpZ2N1: nextState = stJmpZ2N2;

			stJmp1: nextState = stJmp2;
			stJmp2: nextState = stJmp3;
			stJmp3: nextState = stJmp4;

			// Only reset leaves here
			stEndOp: nextState = stEndOp;

			// Single-step ops and last steps
			default: nextState = stFetch1;
		endcase
	end

endmodule
